// ==== compile.f ====
+incdir+design
design/dcache_pkg.sv
design/dcache_way.sv
design/dcache_ctrl.sv
design/dcache_top.sv
test/dcache_ram_model.sv
test/dcache_props.sv
test/dcache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dcache_tb
FILELIST  = compile.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Finished with no errors
SRCS      = $(shell grep -v '^+' $(FILELIST)) design/dcache_consts.svh

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

check:
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== test/dcache_tb.sv ====
//----------------------------------------
// directed tests for the two-way data cache
// a reference model predicts hits, writebacks and load data
// ram words follow the fill rule of dcache_ram_model
//----------------------------------------
`timescale 1ns/1ns

`include "dcache_consts.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int MAX_CYCLES = 4000;   // covers all tests with a wide margin

    logic    clk;
    logic    rst_n;
    logic    req_i;
    logic    we_i;
    index_t  index_i;
    tag_t    tag_i;
    offset_t offset_i;
    be_t     be_i;
    word_t   wdata_i;
    word_t   rdata_o;
    logic    addr_ack_o, data_ack_o;
    logic    wr_req_o, wr_rdy_i;
    addr_t   wr_addr_o;
    line_t   wr_data_o;
    logic    rd_req_o, rd_rdy_i, rd_valid_i, rd_last_i;
    addr_t   rd_addr_o;
    word_t   rd_data_i;
    int      ram_delay;

    // reference model
    word_t   img [addr_t];               // current value of every word
    tag_t    m_tag   [2][`DC_SETS];
    logic    m_valid [2][`DC_SETS];
    logic    m_dirty [2][`DC_SETS];
    logic    m_lru   [`DC_SETS];         // way to evict next

    word_t   rng_state = 32'd16233;
    int      cycles, checks, errors;
    int      rd_count, wr_count;
    addr_t   last_rd_addr, last_wr_addr;
    line_t   last_wr_data;

    dcache_top DUT (.*);

    dcache_ram_model u_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .delay_i    (ram_delay),
        .wr_req_i   (wr_req_o),
        .wr_addr_i  (wr_addr_o),
        .wr_data_i  (wr_data_o),
        .wr_rdy_o   (wr_rdy_i),
        .rd_req_i   (rd_req_o),
        .rd_addr_i  (rd_addr_o),
        .rd_rdy_o   (rd_rdy_i),
        .rd_data_o  (rd_data_i),
        .rd_valid_o (rd_valid_i),
        .rd_last_o  (rd_last_i)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("checks: %0d, errors: %0d, assertion failures: %0d",
                     checks, errors, DUT.u_props.fail_count);
            $display("Finished with errors");
            $finish;
        end
    end

    // ram transfers sampled at the falling edge
    always @(negedge clk) begin
        if (rd_req_o && rd_rdy_i) begin
            rd_count++;
            last_rd_addr = rd_addr_o;
        end
        if (wr_req_o && wr_rdy_i) begin
            wr_count++;
            last_wr_addr = wr_addr_o;
            last_wr_data = wr_data_o;
        end
    end

    //----------------------------------------
    // helpers
    //----------------------------------------
    function automatic word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t img_word(addr_t a);
        if (img.exists(a)) begin
            return img[a];
        end
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic addr_t make_addr(tag_t t, index_t s, logic [1:0] w);
        return {t, s, w, 2'b00};
    endfunction

    task automatic compare(input string what, input line_t exp, input line_t got);
        checks++;
        assert (exp === got) else begin
            errors++;
            $display("[ERROR] %0t: %s expected %0h, got %0h", $time, what, exp, got);
        end
    endtask

    // one cpu request with its load data and the latency from accept to data_ack
    task automatic run_request(input logic we, input addr_t addr, input be_t be,
                               input word_t wdata, output word_t rdata, output int lat);
        req_i    = 1'b1;
        we_i     = we;
        tag_i    = addr[31:8];
        index_i  = addr[7:4];
        offset_i = addr[3:0];
        be_i     = be;
        wdata_i  = wdata;
        do @(negedge clk); while (!addr_ack_o);
        @(posedge clk);
        #5;
        req_i = 1'b0;
        lat   = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!data_ack_o);
        rdata = rdata_o;
        @(posedge clk);
        #5;
    endtask

    // predict, run, compare and update the model
    task automatic check_access(input logic we, input addr_t addr, input be_t be,
                                input word_t wdata, output logic hit_seen);
        index_t set;
        tag_t   tag;
        int     way;
        int     lat;
        int     rd0, wr0;
        logic   exp_hit, exp_wb;
        addr_t  wb_addr;
        line_t  wb_line;
        word_t  exp_word, got;
        set     = addr[7:4];
        tag     = addr[31:8];
        exp_hit = 1'b0;
        exp_wb  = 1'b0;
        way     = 0;
        wb_addr = '0;
        wb_line = '0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][set] && m_tag[w][set] == tag) begin
                exp_hit = 1'b1;
                way     = w;
            end
        end
        if (!exp_hit) begin
            if (!m_valid[0][set]) way = 0;
            else if (!m_valid[1][set]) way = 1;
            else way = int'(m_lru[set]);
            if (m_valid[way][set] && m_dirty[way][set]) begin
                exp_wb  = 1'b1;
                wb_addr = {m_tag[way][set], set, 4'h0};
                for (int k = 0; k < `DC_WORDS; k++) begin
                    wb_line[k*32 +: 32] = img_word(wb_addr + addr_t'(4 * k));
                end
            end
        end
        exp_word = img_word({addr[31:2], 2'b00});
        for (int b = 0; b < `DC_BE_W; b++) begin
            if (we && be[b]) exp_word[b*8 +: 8] = wdata[b*8 +: 8];
        end
        rd0 = rd_count;
        wr0 = wr_count;
        run_request(we, addr, be, wdata, got, lat);
        if (exp_hit) begin
            compare("hit latency", line_t'(1), line_t'(lat));
            compare("refills on hit", line_t'(rd0), line_t'(rd_count));
        end else begin
            compare("refill count", line_t'(rd0 + 1), line_t'(rd_count));
            compare("refill address", line_t'({addr[31:4], 4'h0}), line_t'(last_rd_addr));
        end
        compare("writeback count", line_t'(wr0 + (exp_wb ? 1 : 0)), line_t'(wr_count));
        if (exp_wb) begin
            compare("writeback address", line_t'(wb_addr), line_t'(last_wr_addr));
            compare("writeback line", wb_line, last_wr_data);
        end
        if (we) img[{addr[31:2], 2'b00}] = exp_word;
        else compare("load data", line_t'(exp_word), line_t'(got));
        if (!exp_hit) begin
            m_tag[way][set]   = tag;
            m_valid[way][set] = 1'b1;
            m_dirty[way][set] = 1'b0;    // refill is clean
        end
        if (we) m_dirty[way][set] = 1'b1;
        m_lru[set] = (way == 0);
        hit_seen = (lat == 1) && (rd_count == rd0) && (wr_count == wr0);
    endtask

    //----------------------------------------
    // tests
    //----------------------------------------
    task automatic check_reset();
        repeat (16) begin
            @(negedge clk);
            compare("addr_ack_o in reset", '0, line_t'(addr_ack_o));
            compare("data_ack_o in reset", '0, line_t'(data_ack_o));
            compare("rd_req_o in reset", '0, line_t'(rd_req_o));
            compare("wr_req_o in reset", '0, line_t'(wr_req_o));
        end
        @(posedge clk);
        #5;
        rst_n = 1'b1;
        @(negedge clk);
        compare("outputs after reset",
                '0, line_t'({addr_ack_o, data_ack_o, rd_req_o, wr_req_o}));
        @(posedge clk);
        #5;
    endtask

    task automatic test_load_miss_hit();
        logic hit;
        check_access(1'b0, make_addr(24'h000101, 4'h3, 2'd1), 4'hf, '0, hit);
        compare("first load misses", '0, line_t'(hit));
        check_access(1'b0, make_addr(24'h000101, 4'h3, 2'd3), 4'hf, '0, hit);
        compare("second load hits", line_t'(1), line_t'(hit));
    endtask

    task automatic test_store_merge();
        addr_t a;
        logic  hit;
        a = make_addr(24'h000101, 4'h3, 2'd2);    // line cached by the previous test
        check_access(1'b1, a, 4'b0110, next_random(), hit);
        compare("partial store hits", line_t'(1), line_t'(hit));
        check_access(1'b0, a, 4'hf, '0, hit);
        compare("load of merged word hits", line_t'(1), line_t'(hit));
    endtask

    task automatic test_eviction();
        logic hit;
        int   wr0;
        check_access(1'b0, make_addr(24'h00a001, 4'h5, 2'd0), 4'hf, '0, hit);
        check_access(1'b1, make_addr(24'h00a001, 4'h5, 2'd1), 4'hf, next_random(), hit);
        check_access(1'b0, make_addr(24'h00a002, 4'h5, 2'd0), 4'hf, '0, hit);
        wr0 = wr_count;
        check_access(1'b0, make_addr(24'h00a003, 4'h5, 2'd2), 4'hf, '0, hit);
        compare("dirty victim written back", line_t'(wr0 + 1), line_t'(wr_count));
        wr0 = wr_count;
        check_access(1'b0, make_addr(24'h00a001, 4'h5, 2'd1), 4'hf, '0, hit);
        compare("clean victim dropped", line_t'(wr0), line_t'(wr_count));
    endtask

    task automatic test_lru();
        logic hit;
        check_access(1'b0, make_addr(24'h0b0001, 4'h9, 2'd0), 4'hf, '0, hit);
        check_access(1'b0, make_addr(24'h0b0002, 4'h9, 2'd0), 4'hf, '0, hit);
        check_access(1'b0, make_addr(24'h0b0001, 4'h9, 2'd1), 4'hf, '0, hit);
        check_access(1'b0, make_addr(24'h0b0003, 4'h9, 2'd0), 4'hf, '0, hit);
        check_access(1'b0, make_addr(24'h0b0001, 4'h9, 2'd2), 4'hf, '0, hit);
        compare("recently used line kept", line_t'(1), line_t'(hit));
    endtask

    task automatic test_backpressure();
        logic hit;
        ram_delay = 6;
        check_access(1'b1, make_addr(24'h0a0a0a, 4'hc, 2'd2), 4'hf, next_random(), hit);
        check_access(1'b1, make_addr(24'h0b0b0b, 4'hc, 2'd0), 4'b1001, next_random(), hit);
        check_access(1'b0, make_addr(24'h0c0c0c, 4'hc, 2'd3), 4'hf, '0, hit);
        check_access(1'b0, make_addr(24'h0a0a0a, 4'hc, 2'd2), 4'hf, '0, hit);
        check_access(1'b0, make_addr(24'h0b0b0b, 4'hc, 2'd0), 4'hf, '0, hit);
        ram_delay = 0;
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_i     = 1'b0;
        we_i      = 1'b0;
        index_i   = '0;
        tag_i     = '0;
        offset_i  = '0;
        be_i      = '0;
        wdata_i   = '0;
        ram_delay = 0;
        for (int s = 0; s < `DC_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        check_reset();
        test_load_miss_hit();
        test_store_merge();
        test_eviction();
        test_lru();
        test_backpressure();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, DUT.u_props.fail_count);
        if (errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== test/dcache_props.sv ====
//----------------------------------------
// handshake checks, bound into dcache_top
// all checks are off while rst_n is low
//----------------------------------------
`timescale 1ns/1ns

module dcache_props import dcache_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  addr_ack_i,
    input logic  data_ack_i,
    input logic  wr_req_i,
    input addr_t wr_addr_i,
    input line_t wr_data_i,
    input logic  wr_rdy_i,
    input logic  rd_req_i,
    input addr_t rd_addr_i,
    input logic  rd_rdy_i
);

    logic open_q;          // accepted request still waiting for data_ack
    int   fail_count = 0;  // assertion failures so far

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            open_q <= 1'b0;
        end else if (addr_ack_i) begin
            open_q <= 1'b1;
        end else if (data_ack_i) begin
            open_q <= 1'b0;
        end
    end

    rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_i && !rd_rdy_i |=> rd_req_i && $stable(rd_addr_i))
        else begin
            fail_count++;
            $error("read request dropped or its address changed before rd_rdy_i");
        end

    wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req_i && !wr_rdy_i |=> wr_req_i && $stable(wr_addr_i) && $stable(wr_data_i))
        else begin
            fail_count++;
            $error("write request dropped or its address or data changed before wr_rdy_i");
        end

    one_channel: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_req_i && wr_req_i))
        else begin
            fail_count++;
            $error("read and write requests are high in the same cycle");
        end

    ack_order: assert property (@(posedge clk) disable iff (!rst_n)
        data_ack_i |-> open_q)
        else begin
            fail_count++;
            $error("data_ack_o rose with no accepted request");
        end

endmodule

bind dcache_top dcache_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr_ack_i (addr_ack_o),
    .data_ack_i (data_ack_o),
    .wr_req_i   (wr_req_o),
    .wr_addr_i  (wr_addr_o),
    .wr_data_i  (wr_data_o),
    .wr_rdy_i   (wr_rdy_i),
    .rd_req_i   (rd_req_o),
    .rd_addr_i  (rd_addr_o),
    .rd_rdy_i   (rd_rdy_i)
);

// ==== test/dcache_ram_model.sv ====
//----------------------------------------
// behavioral line ram for the cache
// unwritten words read back a pattern of their address
// delay_i sets the wait before each rdy
//----------------------------------------
`timescale 1ns/1ns

`include "dcache_consts.svh"

module dcache_ram_model import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  int    delay_i,
    input  logic  wr_req_i,
    input  addr_t wr_addr_i,
    input  line_t wr_data_i,
    output logic  wr_rdy_o,
    input  logic  rd_req_i,
    input  addr_t rd_addr_i,
    output logic  rd_rdy_o,
    output word_t rd_data_o,
    output logic  rd_valid_o,
    output logic  rd_last_o
);

    word_t      mem [addr_t];   // sparse, keyed by byte address
    int         wr_wait;
    int         rd_wait;
    logic       rd_busy;
    addr_t      rd_base;
    logic [1:0] beat;

    function automatic word_t read_word(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_rdy_o   <= 1'b0;
            rd_rdy_o   <= 1'b0;
            rd_data_o  <= '0;
            rd_valid_o <= 1'b0;
            rd_last_o  <= 1'b0;
            rd_busy    <= 1'b0;
            beat       <= 2'd0;
            wr_wait    <= 0;
            rd_wait    <= 0;
        end else begin
            wr_rdy_o   <= 1'b0;
            rd_rdy_o   <= 1'b0;
            rd_valid_o <= 1'b0;
            rd_last_o  <= 1'b0;
            //----------------------------------------
            // write channel
            //----------------------------------------
            if (wr_req_i && wr_rdy_o) begin
                for (int w = 0; w < `DC_WORDS; w++) begin
                    mem[wr_addr_i + addr_t'(4 * w)] = wr_data_i[w*`DC_DATA_W +: `DC_DATA_W];
                end
                wr_wait <= 0;
            end else if (wr_req_i) begin
                if (wr_wait >= delay_i) begin
                    wr_rdy_o <= 1'b1;
                end else begin
                    wr_wait <= wr_wait + 1;
                end
            end
            //----------------------------------------
            // read channel, four beats after accept
            //----------------------------------------
            if (rd_busy) begin
                rd_valid_o <= 1'b1;
                rd_data_o  <= read_word(rd_base + addr_t'({beat, 2'b00}));
                rd_last_o  <= (beat == 2'd3);
                rd_busy    <= (beat != 2'd3);
                beat       <= beat + 2'd1;
            end else if (rd_req_i && rd_rdy_o) begin
                rd_busy <= 1'b1;
                rd_base <= rd_addr_i;
                beat    <= 2'd0;
                rd_wait <= 0;
            end else if (rd_req_i) begin
                if (rd_wait >= delay_i) begin
                    rd_rdy_o <= 1'b1;
                end else begin
                    rd_wait <= rd_wait + 1;
                end
            end
        end
    end

endmodule

// ==== design/dcache_top.sv ====
//----------------------------------------
// two-way data cache, top level
// cpu fields are held until addr_ack_o
//----------------------------------------
`timescale 1ns/1ns

module dcache_top import dcache_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    req_i,
    input  logic    we_i,
    input  index_t  index_i,
    input  tag_t    tag_i,
    input  offset_t offset_i,
    input  be_t     be_i,
    input  word_t   wdata_i,
    output word_t   rdata_o,
    output logic    addr_ack_o,
    output logic    data_ack_o,
    output logic    wr_req_o,
    output addr_t   wr_addr_o,
    output line_t   wr_data_o,
    input  logic    wr_rdy_i,
    output logic    rd_req_o,
    output addr_t   rd_addr_o,
    input  logic    rd_rdy_i,
    input  word_t   rd_data_i,
    input  logic    rd_valid_i,
    input  logic    rd_last_i
);

    // way read data
    tag_t    way0_tag, way1_tag;
    logic    way0_valid, way1_valid;
    logic    way0_dirty, way1_dirty;
    line_t   way0_line, way1_line;
    // shared write port of both ways
    index_t  way_index;
    tag_t    fill_tag;
    line_t   fill_line;
    logic    fill_dirty;
    offset_t store_offset;
    be_t     store_be;
    word_t   store_data;
    logic    way0_fill_en, way1_fill_en;
    logic    way0_store_en, way1_store_en;

    // cpu and ram ports connect by name
    dcache_ctrl u_ctrl (
        .*,
        .way0_tag_i      (way0_tag),
        .way0_valid_i    (way0_valid),
        .way0_dirty_i    (way0_dirty),
        .way0_line_i     (way0_line),
        .way1_tag_i      (way1_tag),
        .way1_valid_i    (way1_valid),
        .way1_dirty_i    (way1_dirty),
        .way1_line_i     (way1_line),
        .index_o         (way_index),
        .fill_tag_o      (fill_tag),
        .fill_line_o     (fill_line),
        .fill_dirty_o    (fill_dirty),
        .store_offset_o  (store_offset),
        .store_be_o      (store_be),
        .store_data_o    (store_data),
        .way0_fill_en_o  (way0_fill_en),
        .way1_fill_en_o  (way1_fill_en),
        .way0_store_en_o (way0_store_en),
        .way1_store_en_o (way1_store_en)
    );

    dcache_way u_way0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .index_i        (way_index),
        .fill_en_i      (way0_fill_en),
        .fill_tag_i     (fill_tag),
        .fill_line_i    (fill_line),
        .fill_dirty_i   (fill_dirty),
        .store_en_i     (way0_store_en),
        .store_offset_i (store_offset),
        .store_be_i     (store_be),
        .store_data_i   (store_data),
        .tag_o          (way0_tag),
        .valid_o        (way0_valid),
        .dirty_o        (way0_dirty),
        .line_o         (way0_line)
    );

    dcache_way u_way1 (
        .clk            (clk),
        .rst_n          (rst_n),
        .index_i        (way_index),
        .fill_en_i      (way1_fill_en),
        .fill_tag_i     (fill_tag),
        .fill_line_i    (fill_line),
        .fill_dirty_i   (fill_dirty),
        .store_en_i     (way1_store_en),
        .store_offset_i (store_offset),
        .store_be_i     (store_be),
        .store_data_i   (store_data),
        .tag_o          (way1_tag),
        .valid_o        (way1_valid),
        .dirty_o        (way1_dirty),
        .line_o         (way1_line)
    );

endmodule

// ==== design/dcache_ctrl.sv ====
//----------------------------------------
// cache controller, one request in flight
// requests are taken only in idle
// refill beats must arrive in order, word 0 first
//----------------------------------------
`timescale 1ns/1ns

`include "dcache_consts.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    // cpu side
    input  logic    req_i,
    input  logic    we_i,
    input  index_t  index_i,
    input  tag_t    tag_i,
    input  offset_t offset_i,
    input  be_t     be_i,
    input  word_t   wdata_i,
    output word_t   rdata_o,
    output logic    addr_ack_o,
    output logic    data_ack_o,
    // ram write channel
    output logic    wr_req_o,
    output addr_t   wr_addr_o,
    output line_t   wr_data_o,
    input  logic    wr_rdy_i,
    // ram read channel
    output logic    rd_req_o,
    output addr_t   rd_addr_o,
    input  logic    rd_rdy_i,
    input  word_t   rd_data_i,
    input  logic    rd_valid_i,
    input  logic    rd_last_i,
    // way read ports
    input  tag_t    way0_tag_i,
    input  logic    way0_valid_i,
    input  logic    way0_dirty_i,
    input  line_t   way0_line_i,
    input  tag_t    way1_tag_i,
    input  logic    way1_valid_i,
    input  logic    way1_dirty_i,
    input  line_t   way1_line_i,
    // way write ports
    output index_t  index_o,
    output tag_t    fill_tag_o,
    output line_t   fill_line_o,
    output logic    fill_dirty_o,
    output offset_t store_offset_o,
    output be_t     store_be_o,
    output word_t   store_data_o,
    output logic    way0_fill_en_o,
    output logic    way1_fill_en_o,
    output logic    way0_store_en_o,
    output logic    way1_store_en_o
);

    main_state_e state_q, state_d;

    // request buffer
    logic    req_we_q;
    index_t  req_index_q;
    tag_t    req_tag_q;
    offset_t req_offset_q;
    be_t     req_be_q;
    word_t   req_wdata_q;

    logic [`DC_SETS-1:0]       lru_q;     // way to evict next, per set
    logic                      vic_q;
    logic                      vic_c;
    logic                      vic_dirty;
    logic [`DC_OFFSET_W-3:0]   beat_q;    // refill word counter
    line_t                     refill_q;
    logic                      way0_hit, way1_hit, hit;
    logic                      store_en, fill_en;
    logic [`DC_OFFSET_W-3:0]   word_sel;

    //----------------------------------------
    // hit compare and victim choice
    //----------------------------------------
    assign way0_hit = way0_valid_i && (way0_tag_i == req_tag_q);
    assign way1_hit = way1_valid_i && (way1_tag_i == req_tag_q);
    assign hit      = way0_hit || way1_hit;

    // invalid way first, otherwise the lru pick
    assign vic_c = !way0_valid_i ? 1'b0 : (!way1_valid_i ? 1'b1 : lru_q[req_index_q]);
    assign vic_dirty = vic_c ? (way1_valid_i && way1_dirty_i) : (way0_valid_i && way0_dirty_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_i) state_d = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                if (hit) begin
                    state_d = ST_IDLE;
                end else if (vic_dirty) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL_REQ;    // clean victim is simply dropped
                end
            end
            ST_WRITEBACK: begin
                if (wr_rdy_i) state_d = ST_REFILL_REQ;
            end
            ST_REFILL_REQ: begin
                if (rd_rdy_i) state_d = ST_REFILL;
            end
            ST_REFILL: begin
                if (rd_valid_i && rd_last_i) state_d = ST_LOOKUP;  // lookup now hits
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            lru_q   <= '0;
            vic_q   <= 1'b0;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_LOOKUP) begin
                if (hit) begin
                    lru_q[req_index_q] <= way0_hit;   // point at the other way
                end else begin
                    vic_q <= vic_c;
                end
            end
            if (state_q != ST_REFILL) begin
                beat_q <= '0;
            end else if (rd_valid_i) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // payload registers, no reset
    always_ff @(posedge clk) begin
        if (addr_ack_o) begin
            req_we_q     <= we_i;
            req_index_q  <= index_i;
            req_tag_q    <= tag_i;
            req_offset_q <= offset_i;
            req_be_q     <= be_i;
            req_wdata_q  <= wdata_i;
        end
        if (state_q == ST_REFILL && rd_valid_i) begin
            refill_q <= fill_line_o;
        end
    end

    //----------------------------------------
    // refill line and way writes
    //----------------------------------------
    always_comb begin
        fill_line_o = refill_q;
        fill_line_o[int'(beat_q)*`DC_DATA_W +: `DC_DATA_W] = rd_data_i;  // current beat
    end

    assign fill_en         = (state_q == ST_REFILL) && rd_valid_i && rd_last_i;
    assign store_en        = (state_q == ST_LOOKUP) && hit && req_we_q;
    assign way0_fill_en_o  = fill_en && !vic_q;
    assign way1_fill_en_o  = fill_en && vic_q;
    assign way0_store_en_o = store_en && way0_hit;
    assign way1_store_en_o = store_en && way1_hit;

    assign index_o        = req_index_q;
    assign fill_tag_o     = req_tag_q;
    assign fill_dirty_o   = 1'b0;        // a store after refill sets it
    assign store_offset_o = req_offset_q;
    assign store_be_o     = req_be_q;
    assign store_data_o   = req_wdata_q;

    //----------------------------------------
    // cpu and ram outputs
    //----------------------------------------
    assign word_sel   = req_offset_q[`DC_OFFSET_W-1:2];
    assign rdata_o    = way1_hit ? way1_line_i[int'(word_sel)*`DC_DATA_W +: `DC_DATA_W]
                                 : way0_line_i[int'(word_sel)*`DC_DATA_W +: `DC_DATA_W];
    assign addr_ack_o = (state_q == ST_IDLE) && req_i;
    assign data_ack_o = (state_q == ST_LOOKUP) && hit;

    assign wr_req_o  = (state_q == ST_WRITEBACK);
    assign wr_addr_o = {(vic_q ? way1_tag_i : way0_tag_i), req_index_q, {`DC_OFFSET_W{1'b0}}};
    assign wr_data_o = vic_q ? way1_line_i : way0_line_i;

    assign rd_req_o  = (state_q == ST_REFILL_REQ);
    assign rd_addr_o = {req_tag_q, req_index_q, {`DC_OFFSET_W{1'b0}}};

endmodule

// ==== design/dcache_way.sv ====
//----------------------------------------
// storage of one cache way
// reads are combinational, writes land on the next edge
// only the valid bits are cleared by reset
//----------------------------------------
`timescale 1ns/1ns

`include "dcache_consts.svh"

module dcache_way import dcache_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  index_t  index_i,
    // whole-line fill from the refill path
    input  logic    fill_en_i,
    input  tag_t    fill_tag_i,
    input  line_t   fill_line_i,
    input  logic    fill_dirty_i,
    // byte-enabled word store
    input  logic    store_en_i,
    input  offset_t store_offset_i,
    input  be_t     store_be_i,
    input  word_t   store_data_i,
    output tag_t    tag_o,
    output logic    valid_o,
    output logic    dirty_o,
    output line_t   line_o
);

    tag_t                tag_mem  [`DC_SETS];
    line_t               data_mem [`DC_SETS];
    logic [`DC_SETS-1:0] dirty_mem;
    logic [`DC_SETS-1:0] valid_q;
    line_t               store_line;   // current line with the store bytes merged in

    // merge enabled bytes into the selected word
    always_comb begin
        store_line = data_mem[index_i];
        for (int b = 0; b < `DC_BE_W; b++) begin
            if (store_be_i[b]) begin
                store_line[int'(store_offset_i[`DC_OFFSET_W-1:2])*`DC_DATA_W + b*8 +: 8] =
                    store_data_i[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill_en_i) begin
            valid_q[index_i] <= 1'b1;
        end
    end

    // fill wins over store
    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_mem[index_i]   <= fill_tag_i;
            data_mem[index_i]  <= fill_line_i;
            dirty_mem[index_i] <= fill_dirty_i;
        end else if (store_en_i) begin
            data_mem[index_i]  <= store_line;
            dirty_mem[index_i] <= 1'b1;
        end
    end

    assign tag_o   = tag_mem[index_i];
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_mem[index_i];
    assign line_o  = data_mem[index_i];

endmodule

// ==== design/dcache_pkg.sv ====
//----------------------------------------
// vector types and controller states
// widths come from the cache geometry macros
//----------------------------------------
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]           addr_t;
    typedef logic [`DC_TAG_W-1:0]            tag_t;
    typedef logic [`DC_INDEX_W-1:0]          index_t;
    typedef logic [`DC_OFFSET_W-1:0]         offset_t;   // upper two bits pick the word
    typedef logic [`DC_DATA_W-1:0]           word_t;
    typedef logic [`DC_WORDS*`DC_DATA_W-1:0] line_t;     // word 0 in the low bits
    typedef logic [`DC_BE_W-1:0]             be_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL_REQ,
        ST_REFILL
    } main_state_e;

endpackage

// ==== design/dcache_consts.svh ====
//----------------------------------------
// fixed geometry of the data cache
// tag + index + offset must add up to the address width
// words per line and byte enables follow from the word width
//----------------------------------------
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

`define DC_ADDR_W   32
`define DC_DATA_W   32
`define DC_INDEX_W  4   // 16 sets
`define DC_OFFSET_W 4   // 16-byte lines
`define DC_TAG_W    24
`define DC_SETS     16
`define DC_WORDS    4
`define DC_BE_W     4

`endif
